/* rs_pkg.sv */
package rs_pkg;

    // operand and rob tag widths
    parameter int DATA_W    = 32;
    parameter int ROB_IDX_W = 5;

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [DATA_W-1:0]    data_t;

    // execution class, also the slot index
    typedef enum logic [1:0] {
        OP_ALU = 2'd0,
        OP_MUL = 2'd1,
        OP_BR  = 2'd2,
        OP_MEM = 2'd3
    } op_class_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_BUSY     = 2'd1,
        ST_COMPLETE = 2'd2
    } status_e;

    // opaque to the station, decoded by the execution unit
    typedef logic [3:0] func_t;

    typedef struct packed {
        logic      valid;
        op_class_e op_class;
        func_t     func;
        data_t     pc;
        data_t     imm;
        rob_idx_t  rd_tag;
        rob_idx_t  src1_tag;
        rob_idx_t  src2_tag;
    } dispatch_t;

    typedef struct packed {
        logic  src1_ready;
        data_t src1_data;
        logic  src2_ready;
        data_t src2_data;
    } rf_read_t;

    typedef struct packed {
        logic     ready;
        rob_idx_t tag;
        data_t    data;
    } operand_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t tag;
        data_t    data;
    } cdb_lane_t;

    // branch lane carries no data, only completion
    typedef struct packed {
        cdb_lane_t alu;
        cdb_lane_t mul;
        cdb_lane_t mem;
        logic      br_valid;
        rob_idx_t  br_tag;
        logic      flush;
    } cdb_t;

    typedef struct packed {
        logic     valid;
        func_t    func;
        data_t    pc;
        data_t    imm;
        rob_idx_t rd_tag;
        operand_t src1;
        operand_t src2;
        status_e  status;
    } rs_entry_t;

    typedef struct packed {
        logic     valid;
        func_t    func;
        data_t    pc;
        data_t    imm;
        rob_idx_t rd_tag;
        data_t    src1_data;
        data_t    src2_data;
    } issue_t;

    // one bit per class, indexed by op_class_e
    typedef logic [3:0] avail_t;

endpackage

/* cdb_snoop.sv */
module cdb_snoop (
    input  rs_pkg::operand_t in,
    input  rs_pkg::cdb_t     cdb,
    output rs_pkg::operand_t out
);

    logic alu_hit;
    logic mul_hit;
    logic mem_hit;

    // tag match per result lane, branch lane has no data
    assign alu_hit = cdb.alu.valid && (cdb.alu.tag == in.tag);
    assign mul_hit = cdb.mul.valid && (cdb.mul.tag == in.tag);
    assign mem_hit = cdb.mem.valid && (cdb.mem.tag == in.tag);

    always_comb begin
        out = in;
        // a ready operand keeps its value
        if (!in.ready) begin
            // alu first, then mul, then mem
            if (alu_hit) begin
                out.ready = 1'b1;
                out.data  = cdb.alu.data;
            end else if (mul_hit) begin
                out.ready = 1'b1;
                out.data  = cdb.mul.data;
            end else if (mem_hit) begin
                out.ready = 1'b1;
                out.data  = cdb.mem.data;
            end
        end
    end

endmodule

/* rs_entry_builder.sv */
module rs_entry_builder (
    input  rs_pkg::dispatch_t dispatch,
    input  rs_pkg::rf_read_t  rf_read,
    input  rs_pkg::cdb_t      cdb,
    output rs_pkg::rs_entry_t new_entry
);

    import rs_pkg::*;

    operand_t src1_rf;
    operand_t src2_rf;
    operand_t src1_cap;
    operand_t src2_cap;

    // operands as seen from the register file
    always_comb begin
        src1_rf.ready = rf_read.src1_ready;
        src1_rf.tag   = dispatch.src1_tag;
        src1_rf.data  = rf_read.src1_data;
        src2_rf.ready = rf_read.src2_ready;
        src2_rf.tag   = dispatch.src2_tag;
        src2_rf.data  = rf_read.src2_data;
    end

    // catch a result broadcast in the dispatch cycle
    cdb_snoop u_snoop_src1 (
        .in  (src1_rf),
        .cdb (cdb),
        .out (src1_cap)
    );

    cdb_snoop u_snoop_src2 (
        .in  (src2_rf),
        .cdb (cdb),
        .out (src2_cap)
    );

    always_comb begin
        new_entry.valid  = dispatch.valid;
        new_entry.func   = dispatch.func;
        new_entry.pc     = dispatch.pc;
        new_entry.imm    = dispatch.imm;
        new_entry.rd_tag = dispatch.rd_tag;
        new_entry.src1   = src1_cap;
        new_entry.src2   = src2_cap;
        new_entry.status = ST_BUSY;
    end

endmodule

/* rs_station_slot.sv */
module rs_station_slot #(
    parameter rs_pkg::op_class_e SLOT_CLASS = rs_pkg::OP_ALU
) (
    input  logic              clk,
    input  logic              rst_n,
    input  rs_pkg::dispatch_t dispatch,
    input  rs_pkg::rs_entry_t new_entry,
    input  rs_pkg::cdb_t      cdb,
    output rs_pkg::issue_t    issue,
    output logic              avail
);

    import rs_pkg::*;

    rs_entry_t entry_q;
    operand_t  src1_woken;
    operand_t  src2_woken;
    logic      load;
    logic      done_hit;
    logic      both_ready;

    // dispatch targets this slot
    assign load = dispatch.valid && (dispatch.op_class == SLOT_CLASS);

    // wakeup of the stored operands
    cdb_snoop u_snoop_src1 (
        .in  (entry_q.src1),
        .cdb (cdb),
        .out (src1_woken)
    );

    cdb_snoop u_snoop_src2 (
        .in  (entry_q.src2),
        .cdb (cdb),
        .out (src2_woken)
    );

    // any lane reporting our destination, branch included
    always_comb begin
        done_hit = 1'b0;
        if (cdb.alu.valid && (cdb.alu.tag == entry_q.rd_tag)) begin
            done_hit = 1'b1;
        end
        if (cdb.mul.valid && (cdb.mul.tag == entry_q.rd_tag)) begin
            done_hit = 1'b1;
        end
        if (cdb.mem.valid && (cdb.mem.tag == entry_q.rd_tag)) begin
            done_hit = 1'b1;
        end
        if (cdb.br_valid && (cdb.br_tag == entry_q.rd_tag)) begin
            done_hit = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        // flush wins over dispatch and wakeup
        if (!rst_n || cdb.flush) begin
            entry_q.valid      <= 1'b0;
            entry_q.status     <= ST_IDLE;
            entry_q.src1.ready <= 1'b0;
            entry_q.src2.ready <= 1'b0;
        end else if (load) begin
            entry_q <= new_entry;
        end else begin
            entry_q.src1 <= src1_woken;
            entry_q.src2 <= src2_woken;
            if ((entry_q.status == ST_BUSY) && done_hit) begin
                entry_q.status <= ST_COMPLETE;
            end
        end
    end

    assign both_ready = entry_q.src1.ready && entry_q.src2.ready;

    // free once idle or done
    assign avail = (entry_q.status == ST_IDLE) || (entry_q.status == ST_COMPLETE);

    always_comb begin
        issue.valid     = entry_q.valid && (entry_q.status == ST_BUSY) && both_ready;
        issue.func      = entry_q.func;
        issue.pc        = entry_q.pc;
        issue.imm       = entry_q.imm;
        issue.rd_tag    = entry_q.rd_tag;
        issue.src1_data = entry_q.src1.data;
        issue.src2_data = entry_q.src2.data;
    end

endmodule

/* reservation_station.sv */
module reservation_station (
    input  logic              clk,
    input  logic              rst_n,
    input  rs_pkg::dispatch_t dispatch,
    input  rs_pkg::rf_read_t  rf_read,
    input  rs_pkg::cdb_t      cdb,
    output rs_pkg::issue_t    issue_alu,
    output rs_pkg::issue_t    issue_mul,
    output rs_pkg::issue_t    issue_br,
    output rs_pkg::issue_t    issue_mem,
    output rs_pkg::avail_t    avail
);

    import rs_pkg::*;

    // shared by all slots, only the matching class loads it
    rs_entry_t new_entry;

    rs_entry_builder u_entry_builder (
        .dispatch  (dispatch),
        .rf_read   (rf_read),
        .cdb       (cdb),
        .new_entry (new_entry)
    );

    rs_station_slot #(.SLOT_CLASS(OP_ALU)) u_slot_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .dispatch  (dispatch),
        .new_entry (new_entry),
        .cdb       (cdb),
        .issue     (issue_alu),
        .avail     (avail[OP_ALU])
    );

    rs_station_slot #(.SLOT_CLASS(OP_MUL)) u_slot_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .dispatch  (dispatch),
        .new_entry (new_entry),
        .cdb       (cdb),
        .issue     (issue_mul),
        .avail     (avail[OP_MUL])
    );

    rs_station_slot #(.SLOT_CLASS(OP_BR)) u_slot_br (
        .clk       (clk),
        .rst_n     (rst_n),
        .dispatch  (dispatch),
        .new_entry (new_entry),
        .cdb       (cdb),
        .issue     (issue_br),
        .avail     (avail[OP_BR])
    );

    rs_station_slot #(.SLOT_CLASS(OP_MEM)) u_slot_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .dispatch  (dispatch),
        .new_entry (new_entry),
        .cdb       (cdb),
        .issue     (issue_mem),
        .avail     (avail[OP_MEM])
    );

endmodule

/* tb_cases.svh */
// row columns are dispatch, rf answer, cdb, expected avail {mem,br,mul,alu}, port and issue
task automatic build_table();
    dispatch_t da;
    dispatch_t dm;
    dispatch_t db;
    dispatch_t dq;
    dispatch_t da2;
    dispatch_t dm2;
    dispatch_t db2;
    cdb_t      both;
    da   = req(OP_ALU, 1, 5, 6);
    dm   = req(OP_MUL, 2, 10, 7);
    db   = req(OP_BR, 3, 13, 14);
    dq   = req(OP_MEM, 4, 16, 17);
    da2  = req(OP_ALU, 5, 20, 21);
    dm2  = req(OP_MUL, 6, 22, 23);
    db2  = req(OP_BR, 7, 24, 25);
    both = lane(LANE_ALU, 16, rnd[8]) | lane(LANE_MUL, 16, rnd[9]) | lane(LANE_MEM, 17, rnd[10]);
    // state right after reset
    add_row('0, '0, '0, 4'b1111, OP_ALU, '0);
    add_row('0, '0, '0, 4'b1111, OP_MUL, '0);
    add_row('0, '0, '0, 4'b1111, OP_BR, '0);
    add_row('0, '0, '0, 4'b1111, OP_MEM, '0);
    // both operands ready from the register file
    add_row(da, rf(1, rnd[0], 1, rnd[1]), '0, 4'b1110, OP_ALU, issued(da, rnd[0], rnd[1]));
    add_row('0, '0, '0, 4'b1110, OP_ALU, issued(da, rnd[0], rnd[1]));
    add_row('0, '0, lane(LANE_ALU, 1, rnd[2]), 4'b1111, OP_ALU, '0);
    // src1 waits on tag 10 and tag 12 is unrelated
    add_row(dm, rf(0, '0, 1, rnd[3]), '0, 4'b1101, OP_MUL, '0);
    add_row('0, '0, lane(LANE_ALU, 12, rnd[4]), 4'b1101, OP_MUL, '0);
    add_row('0, '0, lane(LANE_MUL, 10, rnd[5]), 4'b1101, OP_MUL, issued(dm, rnd[5], rnd[3]));
    add_row('0, '0, lane(LANE_MUL, 2, rnd[6]), 4'b1111, OP_MUL, '0);
    // both sources wait for the mem and then the alu lane
    add_row(db, '0, '0, 4'b1011, OP_BR, '0);
    add_row('0, '0, lane(LANE_MEM, 14, rnd[6]), 4'b1011, OP_BR, '0);
    add_row('0, '0, lane(LANE_ALU, 13, rnd[7]), 4'b1011, OP_BR, issued(db, rnd[7], rnd[6]));
    add_row('0, '0, lane(LANE_BR, 3, '0), 4'b1111, OP_BR, '0);
    // capture in the dispatch cycle where alu beats mul on src1
    add_row(dq, '0, both, 4'b0111, OP_MEM, issued(dq, rnd[8], rnd[10]));
    add_row(da2, rf(1, rnd[11], 1, rnd[12]), '0, 4'b0110, OP_ALU, issued(da2, rnd[11], rnd[12]));
    add_row(dm2, rf(1, rnd[13], 1, rnd[4]), '0, 4'b0100, OP_MUL, issued(dm2, rnd[13], rnd[4]));
    add_row(db2, rf(1, rnd[14], 1, rnd[15]), '0, 4'b0000, OP_BR, issued(db2, rnd[14], rnd[15]));
    // branch lane completes the alu slot only
    add_row('0, '0, lane(LANE_BR, 5, '0), 4'b0001, OP_ALU, '0);
    add_row('0, '0, '0, 4'b0001, OP_MEM, issued(dq, rnd[8], rnd[10]));
    add_row('0, '0, '0, 4'b0001, OP_BR, issued(db2, rnd[14], rnd[15]));
    // flush beats a dispatch in the same cycle
    add_row(da, rf(1, rnd[0], 1, rnd[1]), lane(FLUSH_ALL, 0, '0), 4'b1111, OP_ALU, '0);
    add_row('0, '0, '0, 4'b1111, OP_MUL, '0);
    add_row('0, '0, '0, 4'b1111, OP_BR, '0);
    add_row('0, '0, '0, 4'b1111, OP_MEM, '0);
endtask

/* tb_reservation_station.sv */
module tb_reservation_station;

    import rs_pkg::*;

    localparam logic [31:0] SEED = 32'h0092dcbd;

    // result lane chosen by a table row
    typedef enum logic [2:0] {
        LANE_ALU,
        LANE_MUL,
        LANE_MEM,
        LANE_BR,
        FLUSH_ALL
    } lane_e;

    typedef struct packed {
        dispatch_t disp;
        rf_read_t  rf_ans;
        cdb_t      bus;
        avail_t    exp_avail;
        op_class_e port;
        issue_t    exp_issue;
    } case_t;

    logic      clk;
    logic      rst_n;
    dispatch_t dispatch;
    rf_read_t  rf_read;
    cdb_t      cdb;
    issue_t    issue_alu;
    issue_t    issue_mul;
    issue_t    issue_br;
    issue_t    issue_mem;
    avail_t    avail;

    logic [31:0] lfsr;
    data_t       rnd [16];
    case_t       cases [$];
    int          passes;
    int          errors;

    reservation_station u_reservation_station (
        .clk       (clk),
        .rst_n     (rst_n),
        .dispatch  (dispatch),
        .rf_read   (rf_read),
        .cdb       (cdb),
        .issue_alu (issue_alu),
        .issue_mul (issue_mul),
        .issue_br  (issue_br),
        .issue_mem (issue_mem),
        .avail     (avail)
    );

    always #50 clk = ~clk;

    // galois form, right shift
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic data_t random_word();
        data_t w;
        w = '0;
        repeat (DATA_W) begin
            w = {lfsr[0], w[DATA_W-1:1]};
            lfsr = lfsr_next(lfsr);
        end
        return w;
    endfunction

    function automatic dispatch_t req(op_class_e c, int rd, int s1, int s2);
        dispatch_t d;
        d.valid    = 1'b1;
        d.op_class = c;
        d.func     = rd[3:0];
        d.pc       = {25'h80, rob_idx_t'(rd), 2'b00};
        d.imm      = ~rnd[rd[3:0]];
        d.rd_tag   = rob_idx_t'(rd);
        d.src1_tag = rob_idx_t'(s1);
        d.src2_tag = rob_idx_t'(s2);
        return d;
    endfunction

    function automatic rf_read_t rf(int v1, data_t d1, int v2, data_t d2);
        rf_read_t r;
        r.src1_ready = (v1 != 0);
        r.src1_data  = d1;
        r.src2_ready = (v2 != 0);
        r.src2_data  = d2;
        return r;
    endfunction

    function automatic cdb_t lane(lane_e kind, int tag, data_t data);
        cdb_t      c;
        cdb_lane_t l;
        c       = '0;
        l.valid = 1'b1;
        l.tag   = rob_idx_t'(tag);
        l.data  = data;
        case (kind)
            LANE_ALU: c.alu = l;
            LANE_MUL: c.mul = l;
            LANE_MEM: c.mem = l;
            LANE_BR: begin
                c.br_valid = 1'b1;
                c.br_tag   = rob_idx_t'(tag);
            end
            default: c.flush = 1'b1;
        endcase
        return c;
    endfunction

    // payload is passed through unchanged, operands as given
    function automatic issue_t issued(dispatch_t d, data_t a, data_t b);
        issue_t e;
        e.valid     = 1'b1;
        e.func      = d.func;
        e.pc        = d.pc;
        e.imm       = d.imm;
        e.rd_tag    = d.rd_tag;
        e.src1_data = a;
        e.src2_data = b;
        return e;
    endfunction

    task automatic add_row(dispatch_t d, rf_read_t r, cdb_t c, avail_t a, op_class_e p,
                           issue_t e);
        cases.push_back('{d, r, c, a, p, e});
    endtask

    `include "tb_cases.svh"

    function automatic issue_t port_issue(op_class_e c);
        case (c)
            OP_ALU: return issue_alu;
            OP_MUL: return issue_mul;
            OP_BR: return issue_br;
            default: return issue_mem;
        endcase
    endfunction

    task automatic apply_row(case_t c);
        dispatch = c.disp;
        rf_read  = c.rf_ans;
        cdb      = c.bus;
    endtask

    task automatic check_issue(int row, op_class_e port, issue_t got, issue_t exp);
        logic ok;
        // an idle port only has to keep valid low
        if (exp.valid) begin
            ok = (got === exp);
        end else begin
            ok = (got.valid === 1'b0);
        end
        if (ok) begin
            passes++;
            $display("row %0d issue %s ok", row, port.name());
        end else begin
            errors++;
            $display("Fail at %0t: row %0d issue %s got %h, expected %h",
                     $time, row, port.name(), got, exp);
        end
    endtask

    task automatic check_avail(int row, avail_t got, avail_t exp);
        if (got === exp) begin
            passes++;
            $display("row %0d avail ok", row);
        end else begin
            errors++;
            $display("Fail at %0t: row %0d avail got %b, expected %b", $time, row, got, exp);
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        dispatch = '0;
        rf_read  = '0;
        cdb      = '0;
        passes   = 0;
        errors   = 0;
        lfsr     = SEED;
        foreach (rnd[k]) begin
            rnd[k] = random_word();
        end
        build_table();
        fork
            begin
                #(cases.size() * 100 * 4);
                $display("timeout: the test table did not finish in time");
                $display("FAIL: see errors above");
                $finish;
            end
        join_none
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // drive on the falling edge, check one cycle later
        foreach (cases[i]) begin
            apply_row(cases[i]);
            @(negedge clk);
            check_issue(i, cases[i].port, port_issue(cases[i].port), cases[i].exp_issue);
            check_avail(i, avail, cases[i].exp_avail);
        end
        $display("checks: %0d passed, %0d failed", passes, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
rs_pkg.sv
cdb_snoop.sv
rs_entry_builder.sv
rs_station_slot.sv
reservation_station.sv
tb_reservation_station.sv

/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing
TOP        = tb_reservation_station
RTL_TOP    = reservation_station
FILELIST   = list.f
BUILD_DIR  = obj_dir
PASS_MSG   = PASS: all tests

.PHONY: all lint sim clean

all: sim

# lint the RTL on its own, then together with the testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
